//--- decode_unit.f
rtl/riscv_pkg.sv
rtl/main_decoder.sv
rtl/alu_decoder.sv
rtl/imm_extender.sv
rtl/reg_file.sv
rtl/pipe_reg.sv
rtl/id_stage.sv
rtl/decode_unit.sv
verif/decode_unit_tb.sv

//--- Bender.yml
package:
  name: decode_unit

sources:
  - rtl/riscv_pkg.sv
  - rtl/main_decoder.sv
  - rtl/alu_decoder.sv
  - rtl/imm_extender.sv
  - rtl/reg_file.sv
  - rtl/pipe_reg.sv
  - rtl/id_stage.sv
  - rtl/decode_unit.sv
  - target: test
    files:
      - verif/decode_unit_tb.sv

//--- verif/decode_unit_tb.sv
`timescale 1ns/1ps

module decode_unit_tb;

  import riscv_pkg::*;

  localparam int n_insns     = 3000;
  localparam int cycle_limit = 40000;

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  logic            in_ready;
  if_id_t          in_insn;
  logic            wb_we;
  logic [4:0]      wb_rd_addr;
  logic [xlen-1:0] wb_rd_wdata;
  logic            out_valid;
  logic            out_ready;
  id_ex_t          out_id_ex;

  logic [31:0]     rng;
  logic [xlen-1:0] shadow [0:31];
  // decoded and waiting in the IF/ID slot without register data
  id_ex_t          pend_q [$];
  // captured in the ID/EX slot
  id_ex_t          exp_q [$];
  logic            s_v;
  logic            o_v;

  decode_unit i_decode_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_insn    (in_insn),
    .wb_we      (wb_we),
    .wb_rd_addr (wb_rd_addr),
    .wb_rd_wdata(wb_rd_wdata),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_id_ex  (out_id_ex)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // immediates via arithmetic shift of the reassembled field
  function automatic logic [xlen-1:0] ext_imm(input logic [31:0] w, input imm_fmt_t fmt);
    case (fmt)
      imm_s: return $signed({w[31:25], w[11:7], 20'd0}) >>> 20;
      imm_b: return $signed({w[31], w[7], w[30:25], w[11:8], 20'd0}) >>> 19;
      imm_u: return {w[31:12], 12'd0};
      imm_j: return $signed({w[31], w[19:12], w[20], w[30:21], 12'd0}) >>> 11;
      default: return $signed({w[31:20], 20'd0}) >>> 20;
    endcase
  endfunction

  function automatic alu_ctrl_t funct_alu_ctrl(input logic [2:0] f3, input logic is_reg,
                                               input logic alt);
    case (f3)
      3'b000: return (is_reg && alt) ? alu_sub : alu_add;
      3'b001: return alu_sll;
      3'b010: return alu_slt;
      3'b011: return alu_sltu;
      3'b100: return alu_xor;
      3'b101: return alt ? alu_sra : alu_srl;
      3'b110: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic id_ex_t ref_decode(input if_id_t f);
    id_ex_t      e;
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    imm_fmt_t    fmt;
    logic        ec;
    logic        eb;
    logic        ill;
    w   = f.insn;
    f3  = w[14:12];
    f7  = w[31:25];
    e   = '0;
    fmt = imm_i;
    ec  = 1'b0;
    eb  = 1'b0;
    ill = 1'b0;
    e.pc         = f.pc;
    e.pc_plus_4  = f.pc_plus_4;
    e.mem_size   = size_w;
    case (w[6:0])
      op_lui: begin
        e.is_rd_write = 1'b1;
        e.alu_a_sel   = a_sel_zero;
        e.alu_b_sel   = b_sel_imm;
        fmt           = imm_u;
      end
      op_auipc: begin
        e.is_rd_write = 1'b1;
        e.alu_a_sel   = a_sel_pc;
        e.alu_b_sel   = b_sel_imm;
        fmt           = imm_u;
      end
      op_jal: begin
        e.is_rd_write = 1'b1;
        e.is_jump     = 1'b1;
        e.is_jal      = 1'b1;
        e.alu_a_sel   = a_sel_pc;
        e.alu_b_sel   = b_sel_imm;
        fmt           = imm_j;
      end
      op_jalr: begin
        ill = (f3 != 3'b000);
        if (!ill) begin
          e.is_rd_write = 1'b1;
          e.is_rs1_read = 1'b1;
          e.is_jump     = 1'b1;
          e.is_jalr     = 1'b1;
          e.alu_b_sel   = b_sel_imm;
          e.pc_alu_sel  = pc_sel_rs1;
        end
      end
      op_branch: begin
        ill = (f3 == 3'b010 || f3 == 3'b011);
        if (!ill) begin
          e.is_rs1_read = 1'b1;
          e.is_rs2_read = 1'b1;
          e.is_branch   = 1'b1;
          e.alu_ctrl    = !f3[2] ? alu_sub : (f3[1] ? alu_sltu : alu_slt);
          fmt           = imm_b;
        end
      end
      op_load: begin
        ill = (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111);
        if (!ill) begin
          e.is_rd_write = 1'b1;
          e.is_rs1_read = 1'b1;
          e.is_mem_read = 1'b1;
          e.mem_size    = mem_size_t'(f3);
          e.alu_b_sel   = b_sel_imm;
        end
      end
      op_store: begin
        ill = (f3 > 3'b010);
        if (!ill) begin
          e.is_rs1_read  = 1'b1;
          e.is_rs2_read  = 1'b1;
          e.is_mem_write = 1'b1;
          e.mem_size     = mem_size_t'(f3);
          e.alu_b_sel    = b_sel_imm;
          fmt            = imm_s;
        end
      end
      op_imm: begin
        ill = (f3 == 3'b001 && f7 != 7'h00) ||
              (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
        if (!ill) begin
          e.is_rd_write = 1'b1;
          e.is_rs1_read = 1'b1;
          e.alu_b_sel   = b_sel_imm;
          e.alu_ctrl    = funct_alu_ctrl(f3, 1'b0, w[30]);
        end
      end
      op_reg: begin
        ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        if (!ill) begin
          e.is_rd_write = 1'b1;
          e.is_rs1_read = 1'b1;
          e.is_rs2_read = 1'b1;
          e.alu_ctrl    = funct_alu_ctrl(f3, 1'b1, w[30]);
        end
      end
      op_system: begin
        if (f3 == 3'b000) begin
          ec  = (w[31:7] == 25'd0);
          eb  = (w[31:20] == 12'd1 && w[19:7] == 13'd0);
          ill = !ec && !eb;
        end else if (f3 == 3'b100) begin
          ill = 1'b1;
        end else begin
          e.is_rd_write     = 1'b1;
          e.is_rs1_read     = !f3[2];
          e.csr_bitmask_sel = f3[2] ? csr_mask_zimm : csr_mask_rs1;
          e.csr_rw          = (f3[1:0] == 2'd1);
          e.csr_set         = (f3[1:0] == 2'd2);
          e.csr_clear       = (f3[1:0] == 2'd3);
          e.is_csr_write    = e.csr_rw || (w[19:15] != 5'd0);
          e.is_csr_read     = !e.csr_rw || (w[11:7] != 5'd0);
        end
      end
      default: begin
        ill = 1'b1;
      end
    endcase
    e.imm         = ext_imm(w, fmt);
    e.branch_addr = f.pc + ext_imm(w, imm_b);
    e.rs1_addr    = e.is_rs1_read ? w[19:15] : 5'd0;
    e.rs2_addr    = e.is_rs2_read ? w[24:20] : 5'd0;
    e.rd_addr     = w[11:7];
    e.csr_addr    = w[31:20];
    if (e.rd_addr == 5'd0) begin
      e.is_rd_write = 1'b0;
    end
    e.trap.valid = ec || eb || ill;
    if (e.trap.valid) begin
      e.trap.pc     = f.pc;
      e.trap.mcause = ec ? 32'd11 : (eb ? 32'd3 : 32'd2);
    end
    return e;
  endfunction

  // shadow file seen through a same-cycle write-back
  function automatic logic [xlen-1:0] reg_value(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end
    if (wb_we && wb_rd_addr == addr) begin
      return wb_rd_wdata;
    end
    return shadow[addr];
  endfunction

  function automatic logic [31:0] gen_insn();
    logic [31:0] w;
    logic [31:0] sel;
    w   = rand32();
    sel = rand32();
    // small register numbers so write-backs hit the read ports
    if (sel[0]) begin
      w[19:18] = 2'b00;
      w[24:23] = 2'b00;
    end
    if (sel[3:1] == 3'd0) begin
      w[11:7] = 5'd0;
    end
    case (sel[31:24] % 13)
      0: w[6:0] = op_lui;
      1: w[6:0] = op_auipc;
      2: w[6:0] = op_jal;
      3: begin
        w[6:0] = op_jalr;
        if (sel[5:4] != 2'd0) begin
          w[14:12] = 3'b000;
        end
      end
      4: w[6:0] = op_branch;
      5: w[6:0] = op_load;
      6: w[6:0] = op_store;
      7: begin
        w[6:0] = op_imm;
        if (sel[6]) begin
          w[31:25] = {1'b0, sel[7] && (w[14:12] == 3'b101), 5'd0};
        end
      end
      8: begin
        w[6:0] = op_reg;
        if (sel[8:6] != 3'd0) begin
          w[31:25] = {1'b0, sel[9], 5'd0};
        end
      end
      9: begin
        w[6:0] = op_system;
        if (sel[10]) begin
          w[19:15] = 5'd0;
        end
      end
      10: w = sel[11] ? 32'h0000_0073 : 32'h0010_0073;
      default: begin
        // fully random word that is mostly illegal
      end
    endcase
    return w;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_field(input string name, input logic [xlen-1:0] exp,
                               input logic [xlen-1:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    compare_field(name, {31'd0, exp}, {31'd0, act});
  endtask

  task automatic check_trap(input trap_t exp, input trap_t act);
    compare_field("trap.valid", {31'd0, exp.valid}, {31'd0, act.valid});
    compare_field("trap.pc", exp.pc, act.pc);
    compare_field("trap.mcause", exp.mcause, act.mcause);
  endtask

  task automatic check_id_ex(input id_ex_t exp, input id_ex_t act);
    compare_field("pc", exp.pc, act.pc);
    compare_field("pc_plus_4", exp.pc_plus_4, act.pc_plus_4);
    compare_field("branch_addr", exp.branch_addr, act.branch_addr);
    compare_field("rs1_addr", exp.rs1_addr, act.rs1_addr);
    compare_field("rs2_addr", exp.rs2_addr, act.rs2_addr);
    compare_field("rd_addr", exp.rd_addr, act.rd_addr);
    compare_field("rs1_rdata", exp.rs1_rdata, act.rs1_rdata);
    compare_field("rs2_rdata", exp.rs2_rdata, act.rs2_rdata);
    compare_field("imm", exp.imm, act.imm);
    compare_field("csr_addr", exp.csr_addr, act.csr_addr);
    compare_field("alu_ctrl", exp.alu_ctrl, act.alu_ctrl);
    compare_field("alu_a_sel", exp.alu_a_sel, act.alu_a_sel);
    compare_field("alu_b_sel", exp.alu_b_sel, act.alu_b_sel);
    compare_field("pc_alu_sel", exp.pc_alu_sel, act.pc_alu_sel);
    compare_field("csr_bitmask_sel", exp.csr_bitmask_sel, act.csr_bitmask_sel);
    compare_field("is_branch", exp.is_branch, act.is_branch);
    compare_field("is_jump", exp.is_jump, act.is_jump);
    compare_field("is_jal", exp.is_jal, act.is_jal);
    compare_field("is_jalr", exp.is_jalr, act.is_jalr);
    compare_field("is_csr_write", exp.is_csr_write, act.is_csr_write);
    compare_field("is_csr_read", exp.is_csr_read, act.is_csr_read);
    compare_field("csr_rw", exp.csr_rw, act.csr_rw);
    compare_field("csr_clear", exp.csr_clear, act.csr_clear);
    compare_field("csr_set", exp.csr_set, act.csr_set);
    compare_field("is_rd_write", exp.is_rd_write, act.is_rd_write);
    compare_field("is_rs1_read", exp.is_rs1_read, act.is_rs1_read);
    compare_field("is_rs2_read", exp.is_rs2_read, act.is_rs2_read);
    compare_field("is_mem_read", exp.is_mem_read, act.is_mem_read);
    compare_field("is_mem_write", exp.is_mem_write, act.is_mem_write);
    compare_field("mem_size", exp.mem_size, act.mem_size);
    check_trap(exp.trap, act.trap);
  endtask

  initial begin
    int          accepted;
    int          done;
    int          cycles;
    int          i;
    logic        id_ex_rdy;
    logic        m_in_ready;
    logic        in_fire;
    logic [31:0] r;
    id_ex_t      e;
    if_id_t      next_in;
    rng         = 32'h823b_c4da;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_insn     = '0;
    wb_we       = 1'b0;
    wb_rd_addr  = '0;
    wb_rd_wdata = '0;
    out_ready   = 1'b0;
    for (i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    s_v      = 1'b0;
    o_v      = 1'b0;
    accepted = 0;
    done     = 0;
    cycles   = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    while (done < n_insns && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
      id_ex_rdy  = !o_v || out_ready;
      m_in_ready = !s_v || id_ex_rdy;
      check_flag("in_ready", m_in_ready, in_ready);
      check_flag("out_valid", o_v, out_valid);
      if (o_v && out_ready) begin
        check_id_ex(exp_q.pop_front(), out_id_ex);
        done++;
      end
      // capture into ID/EX reads the registers now
      if (s_v && id_ex_rdy) begin
        e = pend_q.pop_front();
        e.rs1_rdata = reg_value(e.rs1_addr);
        e.rs2_rdata = reg_value(e.rs2_addr);
        exp_q.push_back(e);
      end
      in_fire = in_valid && m_in_ready;
      if (in_fire) begin
        pend_q.push_back(ref_decode(in_insn));
        accepted++;
      end
      if (wb_we && wb_rd_addr != 5'd0) begin
        shadow[wb_rd_addr] = wb_rd_wdata;
      end
      if (id_ex_rdy) begin
        o_v = s_v;
      end
      if (m_in_ready) begin
        s_v = in_valid;
      end

      // an offered instruction stays until it is taken
      if (!in_valid || in_fire) begin
        r = rand32();
        if (accepted < n_insns && r[1:0] != 2'b00) begin
          next_in.insn      = gen_insn();
          next_in.pc        = rand32() & 32'hffff_fffc;
          next_in.pc_plus_4 = next_in.pc + 32'd4;
          in_insn  <= next_in;
          in_valid <= 1'b1;
        end else begin
          in_valid <= 1'b0;
        end
      end
      r = rand32();
      out_ready   <= (r[1:0] != 2'b00);
      wb_we       <= r[3];
      wb_rd_addr  <= r[4] ? {2'b00, r[7:5]} : r[12:8];
      wb_rd_wdata <= rand32();
    end

    if (done != n_insns) begin
      stop_on_error($sformatf("timeout: only %0d of %0d instructions came out", done, n_insns));
    end else begin
      // the last instruction must not come out a second time
      @(posedge clk);
      check_flag("out_valid", 1'b0, out_valid);
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- rtl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  riscv_pkg::if_id_t          in_insn,
  input  logic                       wb_we,
  input  logic [4:0]                 wb_rd_addr,
  input  logic [riscv_pkg::xlen-1:0] wb_rd_wdata,
  output logic                       out_valid,
  input  logic                       out_ready,
  output riscv_pkg::id_ex_t          out_id_ex
);

  import riscv_pkg::*;

  if_id_t          if_id;
  logic            if_id_valid;
  logic            id_ex_ready;
  id_ex_t          id_ex;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_rdata;
  logic [xlen-1:0] rs2_rdata;

  pipe_reg #(
    .payload_t(if_id_t)
  ) if_id_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_insn),
    .out_valid(if_id_valid),
    .out_ready(id_ex_ready),
    .out_data (if_id)
  );

  reg_file #(
    .data_w(xlen)
  ) i_reg_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .wb_we      (wb_we),
    .wb_rd_addr (wb_rd_addr),
    .wb_rd_wdata(wb_rd_wdata),
    .rs1_rdata  (rs1_rdata),
    .rs2_rdata  (rs2_rdata)
  );

  id_stage i_id_stage (
    .if_id    (if_id),
    .rs1_rdata(rs1_rdata),
    .rs2_rdata(rs2_rdata),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .id_ex    (id_ex)
  );

  // register data is captured here with the rest of the bundle
  pipe_reg #(
    .payload_t(id_ex_t)
  ) id_ex_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (if_id_valid),
    .in_ready (id_ex_ready),
    .in_data  (id_ex),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_id_ex)
  );

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  riscv_pkg::if_id_t          if_id,
  input  logic [riscv_pkg::xlen-1:0] rs1_rdata,
  input  logic [riscv_pkg::xlen-1:0] rs2_rdata,
  output logic [4:0]                 rs1_addr,
  output logic [4:0]                 rs2_addr,
  output riscv_pkg::id_ex_t          id_ex
);

  import riscv_pkg::*;

  logic             is_rd_write;
  logic             is_rs1_read;
  logic             is_rs2_read;
  logic             is_branch;
  logic             is_jump;
  logic             is_jal;
  logic             is_jalr;
  logic             is_csr_write;
  logic             is_csr_read;
  logic             csr_rw;
  logic             csr_clear;
  logic             csr_set;
  logic             is_mem_read;
  logic             is_mem_write;
  mem_size_t        mem_size;
  alu_op_t          alu_op;
  imm_fmt_t         imm_fmt;
  alu_a_sel_t       alu_a_sel;
  alu_b_sel_t       alu_b_sel;
  pc_alu_sel_t      pc_alu_sel;
  csr_bitmask_sel_t csr_bitmask_sel;
  logic             ecall;
  logic             ebreak;
  logic             illegal;
  alu_ctrl_t        alu_ctrl;
  logic [xlen-1:0]  imm;
  logic [xlen-1:0]  b_imm;

  main_decoder i_main_decoder (
    .insn           (if_id.insn),
    .is_rd_write    (is_rd_write),
    .is_rs1_read    (is_rs1_read),
    .is_rs2_read    (is_rs2_read),
    .is_branch      (is_branch),
    .is_jump        (is_jump),
    .is_jal         (is_jal),
    .is_jalr        (is_jalr),
    .is_csr_write   (is_csr_write),
    .is_csr_read    (is_csr_read),
    .csr_rw         (csr_rw),
    .csr_clear      (csr_clear),
    .csr_set        (csr_set),
    .is_mem_read    (is_mem_read),
    .is_mem_write   (is_mem_write),
    .mem_size       (mem_size),
    .alu_op         (alu_op),
    .imm_fmt        (imm_fmt),
    .alu_a_sel      (alu_a_sel),
    .alu_b_sel      (alu_b_sel),
    .pc_alu_sel     (pc_alu_sel),
    .csr_bitmask_sel(csr_bitmask_sel),
    .ecall          (ecall),
    .ebreak         (ebreak),
    .illegal        (illegal)
  );

  alu_decoder i_alu_decoder (
    .alu_op     (alu_op),
    .funct3     (if_id.insn[14:12]),
    .opcode_bit5(if_id.insn[5]),
    .funct7_bit5(if_id.insn[30]),
    .alu_ctrl   (alu_ctrl)
  );

  imm_extender i_imm_extender (
    .insn   (if_id.insn),
    .imm_fmt(imm_fmt),
    .imm    (imm)
  );

  // branch target always needs the b offset
  imm_extender i_branch_imm (
    .insn   (if_id.insn),
    .imm_fmt(imm_b),
    .imm    (b_imm)
  );

  // unread sources go to x0 so their data reads zero
  assign rs1_addr = is_rs1_read ? if_id.insn[19:15] : 5'd0;
  assign rs2_addr = is_rs2_read ? if_id.insn[24:20] : 5'd0;

  always_comb begin
    id_ex.pc              = if_id.pc;
    id_ex.pc_plus_4       = if_id.pc_plus_4;
    id_ex.branch_addr     = if_id.pc + b_imm;
    id_ex.rs1_addr        = rs1_addr;
    id_ex.rs2_addr        = rs2_addr;
    id_ex.rd_addr         = if_id.insn[11:7];
    id_ex.rs1_rdata       = rs1_rdata;
    id_ex.rs2_rdata       = rs2_rdata;
    id_ex.imm             = imm;
    id_ex.csr_addr        = if_id.insn[31:20];
    id_ex.alu_ctrl        = alu_ctrl;
    id_ex.alu_a_sel       = alu_a_sel;
    id_ex.alu_b_sel       = alu_b_sel;
    id_ex.pc_alu_sel      = pc_alu_sel;
    id_ex.csr_bitmask_sel = csr_bitmask_sel;
    id_ex.is_branch       = is_branch;
    id_ex.is_jump         = is_jump;
    id_ex.is_jal          = is_jal;
    id_ex.is_jalr         = is_jalr;
    id_ex.is_csr_write    = is_csr_write;
    id_ex.is_csr_read     = is_csr_read;
    id_ex.csr_rw          = csr_rw;
    id_ex.csr_clear       = csr_clear;
    id_ex.csr_set         = csr_set;
    id_ex.is_rd_write     = is_rd_write && (if_id.insn[11:7] != 5'd0);
    id_ex.is_rs1_read     = is_rs1_read;
    id_ex.is_rs2_read     = is_rs2_read;
    id_ex.is_mem_read     = is_mem_read;
    id_ex.is_mem_write    = is_mem_write;
    id_ex.mem_size        = mem_size;
    id_ex.trap            = '0;
    // ecall wins over ebreak over illegal
    if (ecall) begin
      id_ex.trap = '{valid: 1'b1, pc: if_id.pc, mcause: trap_ecall_m};
    end else if (ebreak) begin
      id_ex.trap = '{valid: 1'b1, pc: if_id.pc, mcause: trap_breakpoint};
    end else if (illegal) begin
      id_ex.trap = '{valid: 1'b1, pc: if_id.pc, mcause: trap_illegal_instr};
    end
  end

endmodule

//--- rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // free when empty or draining this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int unsigned data_w = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [4:0]        rs1_addr,
  input  logic [4:0]        rs2_addr,
  input  logic              wb_we,
  input  logic [4:0]        wb_rd_addr,
  input  logic [data_w-1:0] wb_rd_wdata,
  output logic [data_w-1:0] rs1_rdata,
  output logic [data_w-1:0] rs2_rdata
);

  // no storage behind x0
  logic [data_w-1:0] regs [1:31];

  function automatic logic [data_w-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end
    // write-through of a same-cycle write-back
    if (wb_we && addr == wb_rd_addr) begin
      return wb_rd_wdata;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd_addr != 5'd0) begin
      regs[wb_rd_addr] <= wb_rd_wdata;
    end
  end

  always_comb begin
    rs1_rdata = read_port(rs1_addr);
    rs2_rdata = read_port(rs2_addr);
  end

endmodule

//--- rtl/imm_extender.sv
`timescale 1ns/1ps

module imm_extender (
  input  logic [riscv_pkg::xlen-1:0] insn,
  input  riscv_pkg::imm_fmt_t        imm_fmt,
  output logic [riscv_pkg::xlen-1:0] imm
);

  import riscv_pkg::*;

  always_comb begin
    case (imm_fmt)
      imm_i: begin
        imm = {{20{insn[31]}}, insn[31:20]};
      end
      imm_s: begin
        imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      end
      // b and j scramble the offset bits and drop bit 0
      imm_b: begin
        imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end
      imm_u: begin
        imm = {insn[31:12], 12'd0};
      end
      imm_j: begin
        imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- rtl/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
  input  riscv_pkg::alu_op_t   alu_op,
  input  logic [2:0]           funct3,
  input  logic                 opcode_bit5,
  input  logic                 funct7_bit5,
  output riscv_pkg::alu_ctrl_t alu_ctrl
);

  import riscv_pkg::*;

  always_comb begin
    case (alu_op)
      aluop_branch: begin
        // beq/bne compare by subtraction
        case (funct3[2:1])
          2'b10:   alu_ctrl = alu_slt;
          2'b11:   alu_ctrl = alu_sltu;
          default: alu_ctrl = alu_sub;
        endcase
      end
      aluop_funct: begin
        case (funct3)
          // sub exists only for register ops
          3'b000:  alu_ctrl = (opcode_bit5 && funct7_bit5) ? alu_sub : alu_add;
          3'b001:  alu_ctrl = alu_sll;
          3'b010:  alu_ctrl = alu_slt;
          3'b011:  alu_ctrl = alu_sltu;
          3'b100:  alu_ctrl = alu_xor;
          3'b101:  alu_ctrl = funct7_bit5 ? alu_sra : alu_srl;
          3'b110:  alu_ctrl = alu_or;
          default: alu_ctrl = alu_and;
        endcase
      end
      default: begin
        alu_ctrl = alu_add;
      end
    endcase
  end

endmodule

//--- rtl/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
  input  logic [riscv_pkg::xlen-1:0] insn,
  output logic                       is_rd_write,
  output logic                       is_rs1_read,
  output logic                       is_rs2_read,
  output logic                       is_branch,
  output logic                       is_jump,
  output logic                       is_jal,
  output logic                       is_jalr,
  output logic                       is_csr_write,
  output logic                       is_csr_read,
  output logic                       csr_rw,
  output logic                       csr_clear,
  output logic                       csr_set,
  output logic                       is_mem_read,
  output logic                       is_mem_write,
  output riscv_pkg::mem_size_t       mem_size,
  output riscv_pkg::alu_op_t         alu_op,
  output riscv_pkg::imm_fmt_t        imm_fmt,
  output riscv_pkg::alu_a_sel_t      alu_a_sel,
  output riscv_pkg::alu_b_sel_t      alu_b_sel,
  output riscv_pkg::pc_alu_sel_t     pc_alu_sel,
  output riscv_pkg::csr_bitmask_sel_t csr_bitmask_sel,
  output logic                       ecall,
  output logic                       ebreak,
  output logic                       illegal
);

  import riscv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       imm_funct_ok;
  logic       reg_funct_ok;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // shift immediates carry funct7 in the upper bits
  assign imm_funct_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                        (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                        1'b1;
  assign reg_funct_ok = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    is_rd_write     = 1'b0;
    is_rs1_read     = 1'b0;
    is_rs2_read     = 1'b0;
    is_branch       = 1'b0;
    is_jump         = 1'b0;
    is_jal          = 1'b0;
    is_jalr         = 1'b0;
    is_csr_write    = 1'b0;
    is_csr_read     = 1'b0;
    csr_rw          = 1'b0;
    csr_clear       = 1'b0;
    csr_set         = 1'b0;
    is_mem_read     = 1'b0;
    is_mem_write    = 1'b0;
    mem_size        = size_w;
    alu_op          = aluop_add;
    imm_fmt         = imm_i;
    alu_a_sel       = a_sel_rs1;
    alu_b_sel       = b_sel_rs2;
    pc_alu_sel      = pc_sel_pc;
    csr_bitmask_sel = csr_mask_rs1;
    ecall           = 1'b0;
    ebreak          = 1'b0;
    illegal         = 1'b0;
    case (opcode)
      op_lui: begin
        is_rd_write = 1'b1;
        imm_fmt     = imm_u;
        alu_a_sel   = a_sel_zero;
        alu_b_sel   = b_sel_imm;
      end
      op_auipc: begin
        is_rd_write = 1'b1;
        imm_fmt     = imm_u;
        alu_a_sel   = a_sel_pc;
        alu_b_sel   = b_sel_imm;
      end
      op_jal: begin
        is_rd_write = 1'b1;
        is_jump     = 1'b1;
        is_jal      = 1'b1;
        imm_fmt     = imm_j;
        alu_a_sel   = a_sel_pc;
        alu_b_sel   = b_sel_imm;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          is_rd_write = 1'b1;
          is_rs1_read = 1'b1;
          is_jump     = 1'b1;
          is_jalr     = 1'b1;
          alu_b_sel   = b_sel_imm;
          pc_alu_sel  = pc_sel_rs1;
        end else begin
          illegal = 1'b1;
        end
      end
      op_branch: begin
        // funct3 010 and 011 are unused
        if (funct3[2:1] != 2'b01) begin
          is_rs1_read = 1'b1;
          is_rs2_read = 1'b1;
          is_branch   = 1'b1;
          imm_fmt     = imm_b;
          alu_op      = aluop_branch;
        end else begin
          illegal = 1'b1;
        end
      end
      op_load: begin
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
          is_rd_write = 1'b1;
          is_rs1_read = 1'b1;
          is_mem_read = 1'b1;
          mem_size    = mem_size_t'(funct3);
          alu_b_sel   = b_sel_imm;
        end else begin
          illegal = 1'b1;
        end
      end
      op_store: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) begin
          is_rs1_read  = 1'b1;
          is_rs2_read  = 1'b1;
          is_mem_write = 1'b1;
          mem_size     = mem_size_t'(funct3);
          imm_fmt      = imm_s;
          alu_b_sel    = b_sel_imm;
        end else begin
          illegal = 1'b1;
        end
      end
      op_imm: begin
        if (imm_funct_ok) begin
          is_rd_write = 1'b1;
          is_rs1_read = 1'b1;
          alu_op      = aluop_funct;
          alu_b_sel   = b_sel_imm;
        end else begin
          illegal = 1'b1;
        end
      end
      op_reg: begin
        if (reg_funct_ok) begin
          is_rd_write = 1'b1;
          is_rs1_read = 1'b1;
          is_rs2_read = 1'b1;
          alu_op      = aluop_funct;
        end else begin
          illegal = 1'b1;
        end
      end
      op_system: begin
        if (funct3 == 3'b000) begin
          if (insn[31:7] == 25'd0) begin
            ecall = 1'b1;
          end else if (insn[31:7] == {12'h001, 13'd0}) begin
            ebreak = 1'b1;
          end else begin
            illegal = 1'b1;
          end
        end else if (funct3 == 3'b100) begin
          illegal = 1'b1;
        end else begin
          is_rd_write     = 1'b1;
          is_rs1_read     = !funct3[2];
          csr_bitmask_sel = funct3[2] ? csr_mask_zimm : csr_mask_rs1;
          csr_rw          = (funct3[1:0] == 2'b01);
          csr_set         = (funct3[1:0] == 2'b10);
          csr_clear       = (funct3[1:0] == 2'b11);
          // set/clear with a zero mask leaves the CSR alone
          is_csr_write    = csr_rw || (insn[19:15] != 5'd0);
          // csrrw into x0 has no read side effect
          is_csr_read     = !csr_rw || (insn[11:7] != 5'd0);
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- rtl/riscv_pkg.sv
package riscv_pkg;

  parameter int unsigned xlen = 32;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef enum logic [1:0] {
    aluop_add,
    aluop_branch,
    aluop_funct
  } alu_op_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_ctrl_t;

  typedef enum logic [1:0] {
    a_sel_rs1,
    a_sel_pc,
    a_sel_zero
  } alu_a_sel_t;

  typedef enum logic {
    b_sel_rs2,
    b_sel_imm
  } alu_b_sel_t;

  typedef enum logic {
    pc_sel_pc,
    pc_sel_rs1
  } pc_alu_sel_t;

  typedef enum logic {
    csr_mask_rs1,
    csr_mask_zimm
  } csr_bitmask_sel_t;

  typedef enum logic [2:0] {
    imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_fmt_t;

  // encoded as the load/store funct3
  typedef enum logic [2:0] {
    size_b  = 3'b000,
    size_h  = 3'b001,
    size_w  = 3'b010,
    size_bu = 3'b100,
    size_hu = 3'b101
  } mem_size_t;

  localparam logic [xlen-1:0] trap_illegal_instr = 32'd2;
  localparam logic [xlen-1:0] trap_breakpoint    = 32'd3;
  localparam logic [xlen-1:0] trap_ecall_m       = 32'd11;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] mcause;
  } trap_t;

  typedef struct packed {
    logic [xlen-1:0] insn;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus_4;
  } if_id_t;

  typedef struct packed {
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  pc_plus_4;
    logic [xlen-1:0]  branch_addr;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [4:0]       rd_addr;
    logic [xlen-1:0]  rs1_rdata;
    logic [xlen-1:0]  rs2_rdata;
    logic [xlen-1:0]  imm;
    logic [11:0]      csr_addr;
    alu_ctrl_t        alu_ctrl;
    alu_a_sel_t       alu_a_sel;
    alu_b_sel_t       alu_b_sel;
    pc_alu_sel_t      pc_alu_sel;
    csr_bitmask_sel_t csr_bitmask_sel;
    logic             is_branch;
    logic             is_jump;
    logic             is_jal;
    logic             is_jalr;
    logic             is_csr_write;
    logic             is_csr_read;
    logic             csr_rw;
    logic             csr_clear;
    logic             csr_set;
    logic             is_rd_write;
    logic             is_rs1_read;
    logic             is_rs2_read;
    logic             is_mem_read;
    logic             is_mem_write;
    mem_size_t        mem_size;
    trap_t            trap;
  } id_ex_t;

endpackage
